// ==== compile.f ====
+incdir+design
design/cache_pkg.sv
design/sync_fifo.sv
design/bank_dispatch.sv
design/cache_bank.sv
design/bank_drain.sv
design/cache_top.sv
verif/mem_model.sv
verif/cache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ns
TOP       = cache_tb
FILELIST  = compile.f
PASS_MSG  = Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== verif/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb;

    localparam int          CLK_PERIOD = 40;
    localparam logic [31:0] SEED       = 32'h8662d38d;

    // AXI4-Lite OKAY response code
    localparam cache_pkg::axi_resp_t AXI_OKAY = 2'b00;

    typedef struct {
        string            name;
        bit               write;
        cache_pkg::addr_t addr;
        cache_pkg::data_t wdata;
        cache_pkg::strb_t strb;
        cache_pkg::data_t exp_data;
        int               exp_fetch;
    } test_t;

    logic                 clk;
    logic                 arst_n;
    cache_pkg::addr_t     awaddr;
    logic                 awvalid;
    logic                 awready;
    cache_pkg::data_t     wdata;
    cache_pkg::strb_t     wstrb;
    logic                 wvalid;
    logic                 wready;
    cache_pkg::axi_resp_t bresp;
    logic                 bvalid;
    logic                 bready;
    cache_pkg::addr_t     araddr;
    logic                 arvalid;
    logic                 arready;
    cache_pkg::data_t     rdata;
    cache_pkg::axi_resp_t rresp;
    logic                 rvalid;
    logic                 rready;
    cache_pkg::mem_req_t  mem_req;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    logic                 mem_rsp_valid;
    cache_pkg::data_t     mem_rsp_data;
    int                   fetch_count;

    test_t  tests[$];
    integer seed;
    int     errors;
    int     passed;
    bit     table_ready;

    cache_top dut_i (.*);

    mem_model #(.SEED(SEED)) mem_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .fetch_count   (fetch_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_test(input string name, input bit write, input cache_pkg::addr_t addr,
                            input cache_pkg::data_t wdat, input cache_pkg::strb_t strb,
                            input cache_pkg::data_t exp_data, input int exp_fetch);
        test_t t;
        t.name      = name;
        t.write     = write;
        t.addr      = addr;
        t.wdata     = wdat;
        t.strb      = strb;
        t.exp_data  = exp_data;
        t.exp_fetch = exp_fetch;
        tests.push_back(t);
    endtask

    // Initial memory word is A5A5 over the word address
    task automatic load_table;
        add_test("cold_read",        0, 16'h0040, '0, '0, 32'hA5A5_0010, 1);
        add_test("hit_read",         0, 16'h0040, '0, '0, 32'hA5A5_0010, 1);
        add_test("bank1_cold",       0, 16'h0044, '0, '0, 32'hA5A5_0011, 2);
        add_test("bank2_cold",       0, 16'h0048, '0, '0, 32'hA5A5_0012, 3);
        add_test("bank3_cold",       0, 16'h004C, '0, '0, 32'hA5A5_0013, 4);
        add_test("bank0_hit",        0, 16'h0040, '0, '0, 32'hA5A5_0010, 4);
        add_test("bank1_hit",        0, 16'h0044, '0, '0, 32'hA5A5_0011, 4);
        add_test("bank2_hit",        0, 16'h0048, '0, '0, 32'hA5A5_0012, 4);
        add_test("bank3_hit",        0, 16'h004C, '0, '0, 32'hA5A5_0013, 4);
        // Bank 0, set 1, tags 4, 8 and 12
        add_test("lru_a_cold",       0, 16'h0110, '0, '0, 32'hA5A5_0044, 5);
        add_test("lru_b_cold",       0, 16'h0210, '0, '0, 32'hA5A5_0084, 6);
        add_test("lru_a_hit",        0, 16'h0110, '0, '0, 32'hA5A5_0044, 6);
        add_test("lru_c_evicts_b",   0, 16'h0310, '0, '0, 32'hA5A5_00C4, 7);
        add_test("lru_a_kept",       0, 16'h0110, '0, '0, 32'hA5A5_0044, 7);
        add_test("lru_b_refetch",    0, 16'h0210, '0, '0, 32'hA5A5_0084, 8);
        add_test("wr_hit_partial",   1, 16'h0044, 32'h1234_5678, 4'b0011, '0, 8);
        add_test("rd_merged",        0, 16'h0044, '0, '0, 32'hA5A5_5678, 8);
        add_test("wr_miss_partial",  1, 16'h0080, 32'hDEAD_BEEF, 4'b1100, '0, 8);
        add_test("rd_after_wr_miss", 0, 16'h0080, '0, '0, 32'hDEAD_0020, 9);
        add_test("rd_again_hit",     0, 16'h0080, '0, '0, 32'hDEAD_0020, 9);
        add_test("wr_hit_full",      1, 16'h004C, 32'hCAFE_F00D, 4'b1111, '0, 9);
        add_test("rd_full",          0, 16'h004C, '0, '0, 32'hCAFE_F00D, 9);
    endtask

    task automatic issue_read(input cache_pkg::addr_t addr);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
    endtask

    task automatic issue_write(input cache_pkg::addr_t addr, input cache_pkg::data_t wdat,
                               input cache_pkg::strb_t strb);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= wdat;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready))
            @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    // Ready toggles randomly until the handshake lands
    task automatic collect_response(input bit write, output cache_pkg::data_t data,
                                    output cache_pkg::axi_resp_t resp);
        bit got;
        got  = 1'b0;
        data = '0;
        resp = '0;
        while (!got) begin
            @(posedge clk);
            if (write)
                bready <= (($random(seed) & 3) != 0);
            else
                rready <= (($random(seed) & 3) != 0);
            @(negedge clk);
            if (write && bvalid && bready) begin
                resp = bresp;
                got  = 1'b1;
            end else if (!write && rvalid && rready) begin
                data = rdata;
                resp = rresp;
                got  = 1'b1;
            end
        end
        @(posedge clk);
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic check_data(input string name, input cache_pkg::data_t exp,
                              input cache_pkg::data_t act);
        if (act !== exp) begin
            $display("FAIL %s: data expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input cache_pkg::axi_resp_t exp,
                              input cache_pkg::axi_resp_t act);
        if (act !== exp) begin
            $display("FAIL %s: resp expected %b, got %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s: fetch count expected %0d, got %0d", name, exp, act);
            errors++;
        end
    endtask

    initial begin
        wait (table_ready);
        #(tests.size() * 200 * CLK_PERIOD);
        $display("Timeout: the DUT stopped answering before all tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        cache_pkg::data_t     data;
        cache_pkg::axi_resp_t resp;
        int                   err_before;
        seed    = SEED;
        errors  = 0;
        passed  = 0;
        arst_n  <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);

        foreach (tests[i]) begin
            err_before = errors;
            if (tests[i].write)
                issue_write(tests[i].addr, tests[i].wdata, tests[i].strb);
            else
                issue_read(tests[i].addr);
            collect_response(tests[i].write, data, resp);
            @(negedge clk);
            check_resp(tests[i].name, AXI_OKAY, resp);
            if (!tests[i].write)
                check_data(tests[i].name, tests[i].exp_data, data);
            check_count(tests[i].name, tests[i].exp_fetch, fetch_count);
            if (errors == err_before) begin
                passed++;
                $display("ok   %s", tests[i].name);
            end
        end

        $display("%0d tests, %0d passed, %0d errors", tests.size(), passed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/1ns

module mem_model #(
    parameter logic [31:0] SEED = 32'h8662d38d
) (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::mem_req_t mem_req,
    input  logic                mem_req_valid,
    output logic                mem_req_ready,
    output logic                mem_rsp_valid,
    output cache_pkg::data_t    mem_rsp_data,
    output int                  fetch_count
);

    cache_pkg::data_t stored_q [int];
    integer           seed;
    logic             pending_q;
    int               delay_q;

    initial seed = SEED;

    // Untouched words read as A5A5 over the word address
    function automatic cache_pkg::data_t word_at(input int a);
        if (stored_q.exists(a))
            return stored_q[a];
        return {16'hA5A5, 16'(a)};
    endfunction

    always @(posedge clk or negedge arst_n) begin
        int               a;
        cache_pkg::data_t merged;
        if (!arst_n) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            mem_rsp_data  <= '0;
            pending_q     <= 1'b0;
            delay_q       <= 0;
            fetch_count   <= 0;
        end else begin
            mem_rsp_valid <= 1'b0;
            mem_req_ready <= (($random(seed) & 3) != 0);
            if (pending_q) begin
                if (delay_q == 1) begin
                    mem_rsp_valid <= 1'b1;
                    pending_q     <= 1'b0;
                end
                delay_q <= delay_q - 1;
            end else if (mem_req_valid && mem_req_ready) begin
                a = int'(mem_req.addr >> 2);
                pending_q <= 1'b1;
                // Answer after one to four cycles
                delay_q <= 1 + ($random(seed) & 3);
                if (mem_req.write) begin
                    merged = word_at(a);
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.strb[b])
                            merged[8*b +: 8] = mem_req.wdata[8*b +: 8];
                    end
                    stored_q[a] = merged;
                end else begin
                    mem_rsp_data <= word_at(a);
                    fetch_count  <= fetch_count + 1;
                end
            end
        end
    end

endmodule

// ==== design/cache_top.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module cache_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cache_pkg::addr_t     awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  cache_pkg::data_t     wdata,
    input  cache_pkg::strb_t     wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output cache_pkg::axi_resp_t bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  cache_pkg::addr_t     araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output cache_pkg::data_t     rdata,
    output cache_pkg::axi_resp_t rresp,
    output logic                 rvalid,
    input  logic                 rready,
    output cache_pkg::mem_req_t  mem_req,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  cache_pkg::data_t     mem_rsp_data
);

    localparam int NB = `CACHE_NUM_BANKS;

    cache_pkg::bank_req_t           bank_req;
    logic [NB-1:0]                  bank_push;
    logic [NB-1:0]                  bank_full;
    cache_pkg::order_t              order;
    logic                           order_push;
    logic                           order_full;
    cache_pkg::bank_rsp_t [NB-1:0]  bank_rsp;
    logic [NB-1:0]                  bank_rsp_valid;
    logic [NB-1:0]                  bank_rsp_ready;
    cache_pkg::mem_req_t [NB-1:0]   bank_mreq;
    logic [NB-1:0]                  bank_mreq_valid;
    logic [NB-1:0]                  bank_mreq_ready;
    logic [NB-1:0]                  refill_valid;
    cache_pkg::data_t               refill_data;

    bank_dispatch dispatch_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .bank_req   (bank_req),
        .bank_push  (bank_push),
        .bank_full  (bank_full),
        .order      (order),
        .order_push (order_push),
        .order_full (order_full)
    );

    for (genvar i = 0; i < NB; i++) begin : bank_g
        cache_bank bank_i (
            .clk          (clk),
            .arst_n       (arst_n),
            .req_push     (bank_push[i]),
            .req          (bank_req),
            .req_full     (bank_full[i]),
            .rsp          (bank_rsp[i]),
            .rsp_valid    (bank_rsp_valid[i]),
            .rsp_ready    (bank_rsp_ready[i]),
            .mreq         (bank_mreq[i]),
            .mreq_valid   (bank_mreq_valid[i]),
            .mreq_ready   (bank_mreq_ready[i]),
            .refill_valid (refill_valid[i]),
            .refill_data  (refill_data)
        );
    end

    bank_drain drain_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .order           (order),
        .order_push      (order_push),
        .order_full      (order_full),
        .bank_rsp        (bank_rsp),
        .bank_rsp_valid  (bank_rsp_valid),
        .bank_rsp_ready  (bank_rsp_ready),
        .bank_mreq       (bank_mreq),
        .bank_mreq_valid (bank_mreq_valid),
        .bank_mreq_ready (bank_mreq_ready),
        .refill_valid    (refill_valid),
        .refill_data     (refill_data),
        .mem_req         (mem_req),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .bresp           (bresp),
        .bvalid          (bvalid),
        .bready          (bready),
        .rdata           (rdata),
        .rresp           (rresp),
        .rvalid          (rvalid),
        .rready          (rready)
    );

endmodule

// ==== design/bank_drain.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module bank_drain (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  cache_pkg::order_t                            order,
    input  logic                                         order_push,
    output logic                                         order_full,
    input  cache_pkg::bank_rsp_t [`CACHE_NUM_BANKS-1:0]  bank_rsp,
    input  logic [`CACHE_NUM_BANKS-1:0]                  bank_rsp_valid,
    output logic [`CACHE_NUM_BANKS-1:0]                  bank_rsp_ready,
    input  cache_pkg::mem_req_t [`CACHE_NUM_BANKS-1:0]   bank_mreq,
    input  logic [`CACHE_NUM_BANKS-1:0]                  bank_mreq_valid,
    output logic [`CACHE_NUM_BANKS-1:0]                  bank_mreq_ready,
    output logic [`CACHE_NUM_BANKS-1:0]                  refill_valid,
    output cache_pkg::data_t                             refill_data,
    output cache_pkg::mem_req_t                          mem_req,
    output logic                                         mem_req_valid,
    input  logic                                         mem_req_ready,
    input  logic                                         mem_rsp_valid,
    input  cache_pkg::data_t                             mem_rsp_data,
    output cache_pkg::axi_resp_t                         bresp,
    output logic                                         bvalid,
    input  logic                                         bready,
    output cache_pkg::data_t                             rdata,
    output cache_pkg::axi_resp_t                         rresp,
    output logic                                         rvalid,
    input  logic                                         rready
);

    localparam int NB = `CACHE_NUM_BANKS;

    cache_pkg::order_t   ord_head;
    logic                ord_empty;
    logic                take;
    logic                axi_done;
    logic                out_valid_q;
    cache_pkg::data_t    out_data_q;

    cache_pkg::bank_id_t rr_q;
    cache_pkg::bank_id_t gnt_q;
    cache_pkg::bank_id_t pick;
    logic                pick_valid;
    logic                grant;
    logic                busy_q;
    logic                req_pend_q;
    cache_pkg::mem_req_t mem_req_q;

    sync_fifo #(
        .payload_t (cache_pkg::order_t),
        .DEPTH     (4 * `CACHE_FIFO_DEPTH)
    ) order_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (order_push),
        .push_data (order),
        .pop       (axi_done),
        .pop_data  (ord_head),
        .empty     (ord_empty),
        .full      (order_full)
    );

    // Head of the order FIFO picks the next bank to answer
    assign take     = !out_valid_q && !ord_empty && bank_rsp_valid[ord_head.bank];
    assign bvalid   = out_valid_q && ord_head.write;
    assign rvalid   = out_valid_q && !ord_head.write;
    assign bresp    = cache_pkg::RESP_OKAY;
    assign rresp    = cache_pkg::RESP_OKAY;
    assign rdata    = out_data_q;
    assign axi_done = (bvalid && bready) || (rvalid && rready);

    // Round-robin search starting at rr_q
    always_comb begin
        cache_pkg::bank_id_t idx;
        pick       = rr_q;
        pick_valid = 1'b0;
        for (int k = NB - 1; k >= 0; k--) begin
            idx = rr_q + cache_pkg::bank_id_t'(k);
            if (bank_mreq_valid[idx]) begin
                pick       = idx;
                pick_valid = 1'b1;
            end
        end
    end

    assign grant         = !busy_q && pick_valid;
    assign mem_req       = mem_req_q;
    assign mem_req_valid = req_pend_q;
    assign refill_data   = mem_rsp_data;

    always_comb begin
        bank_rsp_ready  = '0;
        bank_mreq_ready = '0;
        refill_valid    = '0;
        if (take)
            bank_rsp_ready[ord_head.bank] = 1'b1;
        if (grant)
            bank_mreq_ready[pick] = 1'b1;
        if (busy_q && mem_rsp_valid)
            refill_valid[gnt_q] = 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= 1'b0;
            busy_q      <= 1'b0;
            req_pend_q  <= 1'b0;
            rr_q        <= '0;
            gnt_q       <= '0;
        end else begin
            if (take)
                out_valid_q <= 1'b1;
            else if (axi_done)
                out_valid_q <= 1'b0;

            if (grant) begin
                busy_q     <= 1'b1;
                req_pend_q <= 1'b1;
                gnt_q      <= pick;
                rr_q       <= pick + 1'b1;
            end else begin
                if (req_pend_q && mem_req_ready)
                    req_pend_q <= 1'b0;
                if (mem_rsp_valid)
                    busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            out_data_q <= bank_rsp[ord_head.bank].data;
        if (grant)
            mem_req_q <= bank_mreq[pick];
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

// ==== design/cache_bank.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module cache_bank (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_push,
    input  cache_pkg::bank_req_t req,
    output logic                 req_full,
    output cache_pkg::bank_rsp_t rsp,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output cache_pkg::mem_req_t  mreq,
    output logic                 mreq_valid,
    input  logic                 mreq_ready,
    input  logic                 refill_valid,
    input  cache_pkg::data_t     refill_data
);

    localparam int NS     = `CACHE_NUM_SETS;
    localparam int NW     = `CACHE_NUM_WAYS;
    localparam int STRB_W = $bits(cache_pkg::strb_t);

    typedef logic [$clog2(NW)-1:0] way_t;
    typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_MEM, S_RESP} state_t;

    state_t               state_q;
    cache_pkg::bank_req_t cur_q;
    cache_pkg::bank_req_t fifo_data;
    cache_pkg::bank_rsp_t rsp_q;
    logic                 fifo_empty;
    logic                 fifo_pop;
    logic                 mreq_sent_q;

    // Tag, data, valid and LRU stores
    cache_pkg::tag_t        tag_q [NS][NW];
    cache_pkg::data_t       data_q [NS][NW];
    logic [NS-1:0][NW-1:0]  valid_q;
    way_t [NS-1:0]          lru_q;

    cache_pkg::set_t set;
    cache_pkg::tag_t tag;
    logic [NW-1:0]   hit_vec;
    logic            hit;
    way_t            hit_way;
    way_t            victim;
    way_t            victim_q;

    sync_fifo #(
        .payload_t (cache_pkg::bank_req_t),
        .DEPTH     (`CACHE_FIFO_DEPTH)
    ) req_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (req_push),
        .push_data (req),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (req_full)
    );

    assign fifo_pop = (state_q == S_IDLE) && !fifo_empty;

    assign set = cur_q.addr[cache_pkg::SET_LSB +: $bits(cache_pkg::set_t)];
    assign tag = cur_q.addr[cache_pkg::TAG_LSB +: $bits(cache_pkg::tag_t)];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NW; w++) begin
            hit_vec[w] = valid_q[set][w] && (tag_q[set][w] == tag);
            if (hit_vec[w])
                hit_way = way_t'(w);
        end
        hit = |hit_vec;
    end

    // Lowest invalid way first, else the LRU way
    always_comb begin
        victim = lru_q[set];
        for (int w = NW - 1; w >= 0; w--) begin
            if (!valid_q[set][w])
                victim = way_t'(w);
        end
    end

    assign mreq.addr  = cur_q.addr;
    assign mreq.wdata = cur_q.wdata;
    assign mreq.strb  = cur_q.strb;
    assign mreq.write = cur_q.write;
    assign mreq_valid = (state_q == S_MEM) && !mreq_sent_q;

    assign rsp       = rsp_q;
    assign rsp_valid = (state_q == S_RESP);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= S_IDLE;
            mreq_sent_q <= 1'b0;
            valid_q     <= '0;
            lru_q       <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (!fifo_empty)
                        state_q <= S_LOOKUP;
                end
                S_LOOKUP: begin
                    if (hit)
                        lru_q[set] <= ~hit_way;
                    // Writes always go through to memory
                    if (hit && !cur_q.write) begin
                        state_q <= S_RESP;
                    end else begin
                        state_q     <= S_MEM;
                        mreq_sent_q <= 1'b0;
                    end
                end
                S_MEM: begin
                    if (mreq_valid && mreq_ready)
                        mreq_sent_q <= 1'b1;
                    if (refill_valid) begin
                        state_q <= S_RESP;
                        if (!cur_q.write) begin
                            valid_q[set][victim_q] <= 1'b1;
                            lru_q[set]             <= ~victim_q;
                        end
                    end
                end
                default: begin
                    if (rsp_ready)
                        state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop)
            cur_q <= fifo_data;
        if (state_q == S_LOOKUP) begin
            victim_q   <= victim;
            rsp_q.hit  <= hit;
            rsp_q.data <= data_q[set][hit_way];
            if (hit && cur_q.write) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (cur_q.strb[b])
                        data_q[set][hit_way][8*b +: 8] <= cur_q.wdata[8*b +: 8];
                end
            end
        end
        // No allocate on write miss
        if (state_q == S_MEM && refill_valid) begin
            rsp_q.data <= refill_data;
            if (!cur_q.write) begin
                tag_q[set][victim_q]  <= tag;
                data_q[set][victim_q] <= refill_data;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        state_q == S_LOOKUP |-> $onehot0(hit_vec));

    assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== design/bank_dispatch.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module bank_dispatch (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cache_pkg::addr_t             awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  cache_pkg::data_t             wdata,
    input  cache_pkg::strb_t             wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    input  cache_pkg::addr_t             araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output cache_pkg::bank_req_t         bank_req,
    output logic [`CACHE_NUM_BANKS-1:0]  bank_push,
    input  logic [`CACHE_NUM_BANKS-1:0]  bank_full,
    output cache_pkg::order_t            order,
    output logic                         order_push,
    input  logic                         order_full
);

    cache_pkg::bank_id_t wr_bank;
    cache_pkg::bank_id_t rd_bank;
    logic                wr_ok;
    logic                rd_ok;

    assign wr_bank = awaddr[cache_pkg::BANK_LSB +: $bits(cache_pkg::bank_id_t)];
    assign rd_bank = araddr[cache_pkg::BANK_LSB +: $bits(cache_pkg::bank_id_t)];

    // AW and W only move together, and writes win over reads
    assign wr_ok = awvalid && wvalid && !bank_full[wr_bank] && !order_full;
    assign rd_ok = arvalid && !wr_ok && !bank_full[rd_bank] && !order_full;

    assign awready = wr_ok;
    assign wready  = wr_ok;
    assign arready = rd_ok;

    always_comb begin
        bank_req.addr  = wr_ok ? awaddr : araddr;
        bank_req.wdata = wdata;
        bank_req.strb  = wr_ok ? wstrb : '0;
        bank_req.write = wr_ok;

        bank_push = '0;
        if (wr_ok)
            bank_push[wr_bank] = 1'b1;
        else if (rd_ok)
            bank_push[rd_bank] = 1'b1;

        order.bank  = wr_ok ? wr_bank : rd_bank;
        order.write = wr_ok;
        order_push  = wr_ok || rd_ok;
    end

    // Master side must hold address while stalled
    assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH = 2
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;

    assign empty    = (count_q == '0);
    assign full     = (count_q == (PTR_W+1)'(DEPTH));
    assign pop_data = mem_q[rd_ptr_q];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem_q[wr_ptr_q] <= push_data;
    end

    // Callers must respect full and empty
    assert property (@(posedge clk) disable iff (!arst_n)
        !(push && full) && !(pop && empty));

endmodule

// ==== design/cache_pkg.sv ====
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_DATA_W-1:0] data_t;
    typedef logic [`CACHE_DATA_W/8-1:0] strb_t;
    typedef logic [$clog2(`CACHE_NUM_BANKS)-1:0] bank_id_t;
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // Address split into byte offset, bank, set and tag
    localparam int BANK_LSB = $clog2(`CACHE_DATA_W / 8);
    localparam int SET_LSB = BANK_LSB + $clog2(`CACHE_NUM_BANKS);
    localparam int TAG_LSB = SET_LSB + $clog2(`CACHE_NUM_SETS);

    typedef logic [$clog2(`CACHE_NUM_SETS)-1:0] set_t;
    typedef logic [`CACHE_ADDR_W-TAG_LSB-1:0] tag_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t strb;
        logic  write;
    } bank_req_t;

    typedef struct packed {
        data_t data;
        logic  hit;
    } bank_rsp_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t strb;
        logic  write;
    } mem_req_t;

    typedef struct packed {
        bank_id_t bank;
        logic     write;
    } order_t;

endpackage

// ==== design/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Bank and set geometry
`define CACHE_NUM_BANKS 4
`define CACHE_NUM_SETS 4
`define CACHE_NUM_WAYS 2

// Bus widths
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 32

// Bank input FIFO depth
// Order FIFO uses four times this
`define CACHE_FIFO_DEPTH 2

`endif
